// File: mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// data word and byte address width
`define WORD_W 32

// register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// memory ports carry word addresses
`define IADDR_W 30

// first instruction fetched after reset
`define TEXT_START 32'h00400000

// low bit of the shamt field in an R-type word
`define SHAMT_LSB 6

`endif

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

   // major opcodes in bits 31:26
   // anything not listed here decodes as a no-op
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDI    = 6'h08,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_e;

   // function codes in bits 5:0 of a SPECIAL word
   // shifts use the shamt field, no variable forms
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SYSCALL = 6'h0c,
      FN_ADD     = 6'h20,
      FN_ADDU    = 6'h21,
      FN_SUB     = 6'h22,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a,
      FN_SLTU    = 6'h2b
   } funct_e;

endpackage

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

   // operation performed in EX
   // branch and jump ops only steer the redirect logic
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_BEQ,
      ALU_BNE,
      ALU_JMP,
      ALU_LUI
   } alu_op_e;

   // operand source in EX
   // FWD_EX takes the EX/MEM result, FWD_MEM the writeback value
   typedef enum logic [1:0] {
      FWD_REG = 2'd0,
      FWD_EX  = 2'd1,
      FWD_MEM = 2'd2
   } fwd_sel_e;

   // source of the value written back
   typedef enum logic {
      WB_ALU  = 1'b0,
      WB_LOAD = 1'b1
   } wb_sel_e;

endpackage

`default_nettype wire

// File: pipe_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_consts.svh"

module pipe_control (
   input  wire                           clk,
   input  wire                           rst_b,
   input  wire [`WORD_W-1:0]             inst_id,
   input  wire                           redirect,
   output logic [`REG_ADDR_W-1:0]        rs_id,
   output logic [`REG_ADDR_W-1:0]        rt_id,
   output logic                          stall,
   output logic                          flush,
   output pipe_pkg::alu_op_e             alu_op,
   output logic                          alu_src_imm,
   output logic                          sign_ext,
   output pipe_pkg::fwd_sel_e            fwd_a,
   output pipe_pkg::fwd_sel_e            fwd_b,
   output logic                          mem_write,
   output pipe_pkg::wb_sel_e             wb_sel,
   output logic                          reg_we,
   output logic [`REG_ADDR_W-1:0]        wb_reg,
   output logic                          halted
);
   import isa_pkg::*;
   import pipe_pkg::*;

   typedef enum logic {RUN, HALTED} halt_state_e;

   halt_state_e            state;
   opcode_e                op_id;
   funct_e                 fn_id;
   logic [`REG_ADDR_W-1:0] rd_id;
   // decoded control for the word in ID
   alu_op_e                alu_op_d;
   logic                   alu_src_imm_d;
   logic                   sign_ext_d;
   logic                   mem_write_d;
   wb_sel_e                wb_sel_d;
   logic                   reg_we_d;
   logic [`REG_ADDR_W-1:0] dest_d;
   logic                   uses_rt_d;
   logic                   syscall_d;
   // EX stage control
   logic                   reg_we_ex;
   logic                   mem_write_ex;
   logic                   syscall_ex;
   wb_sel_e                wb_sel_ex;
   logic [`REG_ADDR_W-1:0] dest_ex;
   logic [`REG_ADDR_W-1:0] rs_ex;
   logic [`REG_ADDR_W-1:0] rt_ex;
   // MEM and WB stage control
   logic                   reg_we_mem;
   logic                   syscall_mem;
   wb_sel_e                wb_sel_mem;
   logic [`REG_ADDR_W-1:0] dest_mem;
   logic                   syscall_wb;
   // hazard terms
   logic                   load_use;
   logic                   halt_pending;
   logic                   bubble;

   // instruction fields
   assign op_id = opcode_e'(inst_id[31:26]);
   assign fn_id = funct_e'(inst_id[5:0]);
   assign rs_id = inst_id[25:21];
   assign rt_id = inst_id[20:16];
   assign rd_id = inst_id[15:11];

   // immediate form is the default, SPECIAL and branches override
   always_comb begin
      alu_op_d      = ALU_ADD;
      alu_src_imm_d = 1'b1;
      sign_ext_d    = 1'b1;
      mem_write_d   = 1'b0;
      wb_sel_d      = WB_ALU;
      reg_we_d      = 1'b1;
      dest_d        = rt_id;
      uses_rt_d     = 1'b0;
      syscall_d     = 1'b0;
      case (op_id)
         OP_SPECIAL: begin
            alu_src_imm_d = 1'b0;
            dest_d        = rd_id;
            uses_rt_d     = 1'b1;
            case (fn_id)
               FN_ADD, FN_ADDU: alu_op_d = ALU_ADD;
               FN_SUB, FN_SUBU: alu_op_d = ALU_SUB;
               FN_AND:          alu_op_d = ALU_AND;
               FN_OR:           alu_op_d = ALU_OR;
               FN_XOR:          alu_op_d = ALU_XOR;
               FN_NOR:          alu_op_d = ALU_NOR;
               FN_SLT:          alu_op_d = ALU_SLT;
               FN_SLTU:         alu_op_d = ALU_SLTU;
               FN_SLL:          alu_op_d = ALU_SLL;
               FN_SRL:          alu_op_d = ALU_SRL;
               FN_SRA:          alu_op_d = ALU_SRA;
               FN_SYSCALL: begin
                  reg_we_d  = 1'b0;
                  syscall_d = 1'b1;
               end
               default:         reg_we_d = 1'b0;
            endcase
         end
         // no overflow trap, so ADDI acts as ADDIU
         OP_ADDI, OP_ADDIU: alu_op_d = ALU_ADD;
         OP_SLTI:           alu_op_d = ALU_SLT;
         OP_ANDI: begin
            alu_op_d   = ALU_AND;
            sign_ext_d = 1'b0;
         end
         OP_ORI: begin
            alu_op_d   = ALU_OR;
            sign_ext_d = 1'b0;
         end
         OP_XORI: begin
            alu_op_d   = ALU_XOR;
            sign_ext_d = 1'b0;
         end
         OP_LUI:            alu_op_d = ALU_LUI;
         OP_LW:             wb_sel_d = WB_LOAD;
         OP_SW: begin
            reg_we_d    = 1'b0;
            mem_write_d = 1'b1;
            uses_rt_d   = 1'b1;
         end
         OP_BEQ, OP_BNE: begin
            alu_op_d      = (op_id == OP_BEQ) ? ALU_BEQ : ALU_BNE;
            alu_src_imm_d = 1'b0;
            reg_we_d      = 1'b0;
            uses_rt_d     = 1'b1;
         end
         OP_J: begin
            alu_op_d = ALU_JMP;
            reg_we_d = 1'b0;
         end
         default:           reg_we_d = 1'b0;
      endcase
      // writes to r0 are dropped here so forwarding never sees them
      if (dest_d == '0) begin
         reg_we_d = 1'b0;
      end
   end

   // load in EX feeding the word in ID, rs compared always
   assign load_use = reg_we_ex && (wb_sel_ex == WB_LOAD) &&
                     ((dest_ex == rs_id) || (uses_rt_d && (dest_ex == rt_id)));
   assign stall = load_use;
   assign flush = redirect;

   // once a SYSCALL has left ID nothing younger may issue
   assign halt_pending = syscall_ex || syscall_mem || syscall_wb || halted;
   assign bubble       = stall || flush || halt_pending;

   // ID/EX control
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         alu_op       <= ALU_ADD;
         alu_src_imm  <= 1'b0;
         sign_ext     <= 1'b0;
         reg_we_ex    <= 1'b0;
         mem_write_ex <= 1'b0;
         syscall_ex   <= 1'b0;
         wb_sel_ex    <= WB_ALU;
         dest_ex      <= '0;
         rs_ex        <= '0;
         rt_ex        <= '0;
      end else if (bubble) begin
         // plain add with no side effects
         alu_op       <= ALU_ADD;
         reg_we_ex    <= 1'b0;
         mem_write_ex <= 1'b0;
         syscall_ex   <= 1'b0;
      end else begin
         alu_op       <= alu_op_d;
         alu_src_imm  <= alu_src_imm_d;
         sign_ext     <= sign_ext_d;
         reg_we_ex    <= reg_we_d;
         mem_write_ex <= mem_write_d;
         syscall_ex   <= syscall_d;
         wb_sel_ex    <= wb_sel_d;
         dest_ex      <= dest_d;
         rs_ex        <= rs_id;
         rt_ex        <= rt_id;
      end
   end

   // EX/MEM and MEM/WB control, never stalled
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         reg_we_mem  <= 1'b0;
         mem_write   <= 1'b0;
         wb_sel_mem  <= WB_ALU;
         dest_mem    <= '0;
         syscall_mem <= 1'b0;
         reg_we      <= 1'b0;
         wb_sel      <= WB_ALU;
         wb_reg      <= '0;
         syscall_wb  <= 1'b0;
      end else begin
         reg_we_mem  <= reg_we_ex;
         mem_write   <= mem_write_ex;
         wb_sel_mem  <= wb_sel_ex;
         dest_mem    <= dest_ex;
         syscall_mem <= syscall_ex;
         reg_we      <= reg_we_mem;
         wb_sel      <= wb_sel_mem;
         wb_reg      <= dest_mem;
         syscall_wb  <= syscall_mem;
      end
   end

   // nearest producer wins
   always_comb begin
      fwd_a = FWD_REG;
      if (reg_we_mem && (dest_mem == rs_ex)) begin
         fwd_a = FWD_EX;
      end else if (reg_we && (wb_reg == rs_ex)) begin
         fwd_a = FWD_MEM;
      end
      fwd_b = FWD_REG;
      if (reg_we_mem && (dest_mem == rt_ex)) begin
         fwd_b = FWD_EX;
      end else if (reg_we && (wb_reg == rt_ex)) begin
         fwd_b = FWD_MEM;
      end
   end

   // halt is sticky until reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         state <= RUN;
      end else if (syscall_wb) begin
         state <= HALTED;
      end
   end
   assign halted = (state == HALTED);

   // a taken branch in EX is never a load, so no stall with it
   a_stall_flush: assert property (@(posedge clk) disable iff (!rst_b)
      !(stall && flush));
   // the pipe has drained of stores by the time halt is set
   a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> !mem_write);

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_consts.svh"

module fetch_unit (
   input  wire                     clk,
   input  wire                     rst_b,
   input  wire                     stall,
   input  wire                     flush,
   input  wire                     halted,
   input  wire                     redirect,
   input  wire [`WORD_W-1:0]       redirect_pc,
   input  wire [`WORD_W-1:0]       inst,
   output logic [`IADDR_W-1:0]     inst_addr,
   output logic [`WORD_W-1:0]      inst_id,
   output logic [`WORD_W-1:0]      pc_id
);

   logic [`WORD_W-1:0] pc;
   logic [`WORD_W-1:0] pc_next;
   logic               hold;

   // fetch freezes on load-use and after halt
   assign hold    = stall || halted;
   assign pc_next = redirect ? redirect_pc : pc + 32'd4;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= `TEXT_START;
      end else if (redirect || !hold) begin
         pc <= pc_next;
      end
   end

   // memory is word addressed
   assign inst_addr = pc[`WORD_W-1:2];

   // IF/ID, zero word is sll r0 and acts as a bubble
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         inst_id <= '0;
         pc_id   <= '0;
      end else if (flush) begin
         inst_id <= '0;
         pc_id   <= '0;
      end else if (!hold) begin
         inst_id <= inst;
         pc_id   <= pc;
      end
   end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_consts.svh"

module reg_file (
   input  wire                      clk,
   input  wire                      rst_b,
   input  wire [`REG_ADDR_W-1:0]    rs_id,
   input  wire [`REG_ADDR_W-1:0]    rt_id,
   input  wire                      reg_we,
   input  wire [`REG_ADDR_W-1:0]    wb_reg,
   input  wire [`WORD_W-1:0]        wb_data,
   output logic [`WORD_W-1:0]       rs_data,
   output logic [`WORD_W-1:0]       rt_data
);

   logic [`WORD_W-1:0] regs [`NUM_REGS];

   // single write port from WB, r0 is never written
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_we && (wb_reg != '0)) begin
         regs[wb_reg] <= wb_data;
      end
   end

   // read with bypass of the value being written this cycle
   function automatic logic [`WORD_W-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
      if (addr == '0) begin
         return '0;
      end
      if (reg_we && (addr == wb_reg)) begin
         return wb_data;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rs_data = read_port(rs_id);
      rt_data = read_port(rt_id);
   end

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_consts.svh"

module exec_unit (
   input  wire                        clk,
   input  wire                        rst_b,
   input  wire                        flush,
   input  wire                        stall,
   input  wire [`WORD_W-1:0]          pc_id,
   input  wire [`WORD_W-1:0]          inst_id,
   input  wire [`WORD_W-1:0]          rs_data,
   input  wire [`WORD_W-1:0]          rt_data,
   input  wire pipe_pkg::alu_op_e     alu_op,
   input  wire                        alu_src_imm,
   input  wire                        sign_ext,
   input  wire pipe_pkg::fwd_sel_e    fwd_a,
   input  wire pipe_pkg::fwd_sel_e    fwd_b,
   input  wire [`WORD_W-1:0]          wb_data,
   output logic                       redirect,
   output logic [`WORD_W-1:0]         redirect_pc,
   output logic [`WORD_W-1:0]         alu_result_mem,
   output logic [`WORD_W-1:0]         store_data_mem
);
   import pipe_pkg::*;

   logic [`WORD_W-1:0] pc_ex;
   logic [`WORD_W-1:0] rs_ex;
   logic [`WORD_W-1:0] rt_ex;
   // low 26 bits hold the immediate, shamt and jump index
   logic [25:0]        index_ex;
   logic [15:0]        imm;
   logic [4:0]         shamt;
   logic [`WORD_W-1:0] imm_sext;
   logic [`WORD_W-1:0] imm_ext;
   logic [`WORD_W-1:0] op_a;
   logic [`WORD_W-1:0] op_b;
   logic [`WORD_W-1:0] alu_b;
   logic [`WORD_W-1:0] alu_result;
   logic [`WORD_W-1:0] pc_plus4;
   logic [`WORD_W-1:0] br_target;
   logic [`WORD_W-1:0] j_target;
   logic               id_ex_en;

   // a bubble keeps the old operands, control already ignores them
   assign id_ex_en = !(stall || flush);

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc_ex    <= '0;
         rs_ex    <= '0;
         rt_ex    <= '0;
         index_ex <= '0;
      end else if (id_ex_en) begin
         pc_ex    <= pc_id;
         rs_ex    <= rs_data;
         rt_ex    <= rt_data;
         index_ex <= inst_id[25:0];
      end
   end

   assign imm      = index_ex[15:0];
   assign shamt    = index_ex[`SHAMT_LSB +: 5];
   assign imm_sext = {{(`WORD_W-16){imm[15]}}, imm};
   // logical immediates are zero extended
   assign imm_ext  = sign_ext ? imm_sext : {{(`WORD_W-16){1'b0}}, imm};

   function automatic logic [`WORD_W-1:0] fwd_mux(input fwd_sel_e sel,
                                                  input logic [`WORD_W-1:0] reg_val,
                                                  input logic [`WORD_W-1:0] ex_val,
                                                  input logic [`WORD_W-1:0] mem_val);
      case (sel)
         FWD_EX:  return ex_val;
         FWD_MEM: return mem_val;
         default: return reg_val;
      endcase
   endfunction

   assign op_a  = fwd_mux(fwd_a, rs_ex, alu_result_mem, wb_data);
   assign op_b  = fwd_mux(fwd_b, rt_ex, alu_result_mem, wb_data);
   assign alu_b = alu_src_imm ? imm_ext : op_b;

   always_comb begin
      case (alu_op)
         ALU_SUB:  alu_result = op_a - alu_b;
         ALU_AND:  alu_result = op_a & alu_b;
         ALU_OR:   alu_result = op_a | alu_b;
         ALU_XOR:  alu_result = op_a ^ alu_b;
         ALU_NOR:  alu_result = ~(op_a | alu_b);
         ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(alu_b)};
         ALU_SLTU: alu_result = {31'b0, op_a < alu_b};
         // shifts take rt and the shamt field
         ALU_SLL:  alu_result = op_b << shamt;
         ALU_SRL:  alu_result = op_b >> shamt;
         ALU_SRA:  alu_result = $signed(op_b) >>> shamt;
         ALU_LUI:  alu_result = {imm, 16'h0000};
         default:  alu_result = op_a + alu_b;
      endcase
   end

   // branch compare uses both registers
   always_comb begin
      case (alu_op)
         ALU_BEQ: redirect = (op_a == op_b);
         ALU_BNE: redirect = (op_a != op_b);
         ALU_JMP: redirect = 1'b1;
         default: redirect = 1'b0;
      endcase
   end

   assign pc_plus4    = pc_ex + 32'd4;
   assign br_target   = pc_plus4 + {imm_sext[`WORD_W-3:0], 2'b00};
   // jump stays inside the current 256 MB region
   assign j_target    = {pc_plus4[31:28], index_ex, 2'b00};
   assign redirect_pc = (alu_op == ALU_JMP) ? j_target : br_target;

   // EX/MEM
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         alu_result_mem <= '0;
         store_data_mem <= '0;
      end else begin
         alu_result_mem <= alu_result;
         store_data_mem <= op_b;
      end
   end

   // fetch only ever hands over aligned PCs
   a_target_aligned: assert property (@(posedge clk) disable iff (!rst_b)
      redirect |-> (redirect_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: mem_wb_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_consts.svh"

module mem_wb_unit (
   input  wire                       clk,
   input  wire                       rst_b,
   input  wire [`WORD_W-1:0]         alu_result_mem,
   input  wire [`WORD_W-1:0]         store_data_mem,
   input  wire                       mem_write,
   input  wire pipe_pkg::wb_sel_e    wb_sel,
   input  wire [`WORD_W-1:0]         mem_rdata,
   output logic [`IADDR_W-1:0]       mem_addr,
   output logic [`WORD_W-1:0]        mem_wdata,
   output logic                      mem_we,
   output logic [`WORD_W-1:0]        wb_data
);
   import pipe_pkg::*;

   logic [`WORD_W-1:0] load_wb;
   logic [`WORD_W-1:0] alu_wb;

   // word accesses only, low address bits dropped
   assign mem_addr  = alu_result_mem[`WORD_W-1:2];
   assign mem_wdata = store_data_mem;
   assign mem_we    = mem_write;

   // MEM/WB, read data arrives in the same cycle
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         load_wb <= '0;
         alu_wb  <= '0;
      end else begin
         load_wb <= mem_rdata;
         alu_wb  <= alu_result_mem;
      end
   end

   assign wb_data = (wb_sel == WB_LOAD) ? load_wb : alu_wb;

endmodule

`default_nettype wire

// File: mips_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_consts.svh"

module mips_core (
   input  wire                    clk,
   input  wire                    rst_b,
   output logic [`IADDR_W-1:0]    inst_addr,
   input  wire [`WORD_W-1:0]      inst,
   output logic [`IADDR_W-1:0]    mem_addr,
   output logic [`WORD_W-1:0]     mem_wdata,
   output logic                   mem_we,
   input  wire [`WORD_W-1:0]      mem_rdata,
   output logic                   halted
);
   import pipe_pkg::*;

   // IF/ID outputs
   logic [`WORD_W-1:0]     inst_id;
   logic [`WORD_W-1:0]     pc_id;
   // register file ports
   logic [`REG_ADDR_W-1:0] rs_id;
   logic [`REG_ADDR_W-1:0] rt_id;
   logic [`WORD_W-1:0]     rs_data;
   logic [`WORD_W-1:0]     rt_data;
   // pipeline steering
   logic                   stall;
   logic                   flush;
   logic                   redirect;
   logic [`WORD_W-1:0]     redirect_pc;
   // EX control
   alu_op_e                alu_op;
   logic                   alu_src_imm;
   logic                   sign_ext;
   fwd_sel_e               fwd_a;
   fwd_sel_e               fwd_b;
   // MEM and WB
   logic                   mem_write;
   wb_sel_e                wb_sel;
   logic                   reg_we;
   logic [`REG_ADDR_W-1:0] wb_reg;
   logic [`WORD_W-1:0]     wb_data;
   logic [`WORD_W-1:0]     alu_result_mem;
   logic [`WORD_W-1:0]     store_data_mem;

   pipe_control u_ctrl (
      .clk         (clk),
      .rst_b       (rst_b),
      .inst_id     (inst_id),
      .redirect    (redirect),
      .rs_id       (rs_id),
      .rt_id       (rt_id),
      .stall       (stall),
      .flush       (flush),
      .alu_op      (alu_op),
      .alu_src_imm (alu_src_imm),
      .sign_ext    (sign_ext),
      .fwd_a       (fwd_a),
      .fwd_b       (fwd_b),
      .mem_write   (mem_write),
      .wb_sel      (wb_sel),
      .reg_we      (reg_we),
      .wb_reg      (wb_reg),
      .halted      (halted)
   );

   fetch_unit u_fetch (
      .clk         (clk),
      .rst_b       (rst_b),
      .stall       (stall),
      .flush       (flush),
      .halted      (halted),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .inst        (inst),
      .inst_addr   (inst_addr),
      .inst_id     (inst_id),
      .pc_id       (pc_id)
   );

   reg_file u_rf (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_id   (rs_id),
      .rt_id   (rt_id),
      .reg_we  (reg_we),
      .wb_reg  (wb_reg),
      .wb_data (wb_data),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   exec_unit u_exec (
      .clk            (clk),
      .rst_b          (rst_b),
      .flush          (flush),
      .stall          (stall),
      .pc_id          (pc_id),
      .inst_id        (inst_id),
      .rs_data        (rs_data),
      .rt_data        (rt_data),
      .alu_op         (alu_op),
      .alu_src_imm    (alu_src_imm),
      .sign_ext       (sign_ext),
      .fwd_a          (fwd_a),
      .fwd_b          (fwd_b),
      .wb_data        (wb_data),
      .redirect       (redirect),
      .redirect_pc    (redirect_pc),
      .alu_result_mem (alu_result_mem),
      .store_data_mem (store_data_mem)
   );

   mem_wb_unit u_mem_wb (
      .clk            (clk),
      .rst_b          (rst_b),
      .alu_result_mem (alu_result_mem),
      .store_data_mem (store_data_mem),
      .mem_write      (mem_write),
      .wb_sel         (wb_sel),
      .mem_rdata      (mem_rdata),
      .mem_addr       (mem_addr),
      .mem_wdata      (mem_wdata),
      .mem_we         (mem_we),
      .wb_data        (wb_data)
   );

endmodule

`default_nettype wire

// File: tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_consts.svh"

module tb_mips_core;

   // program and data both fit in 256 words
   localparam int MEM_WORDS = 256;
   localparam logic [`IADDR_W-1:0] MEM_TOP = `IADDR_W'(MEM_WORDS);
   localparam logic [`IADDR_W-1:0] TEXT_W  = `IADDR_W'(`TEXT_START >> 2);
   // cycles watched after halt for a stray store
   localparam int HALT_WATCH = 12;

   logic                clk;
   logic                rst_b;
   logic [`IADDR_W-1:0] inst_addr;
   logic [`WORD_W-1:0]  inst;
   logic [`IADDR_W-1:0] mem_addr;
   logic [`WORD_W-1:0]  mem_wdata;
   logic                mem_we;
   logic [`WORD_W-1:0]  mem_rdata;
   logic                halted;

   logic [`WORD_W-1:0]  imem [MEM_WORDS];
   logic [`WORD_W-1:0]  dmem [MEM_WORDS];
   logic [`IADDR_W-1:0] inst_off;
   // expected stores in program order
   logic [`WORD_W-1:0]  exp_addr [$];
   logic [`WORD_W-1:0]  exp_data [$];
   int                  prog_words;
   int                  store_count;
   int                  cycle_limit;
   int                  cycles;

   mips_core uut (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst_addr (inst_addr),
      .inst      (inst),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .mem_rdata (mem_rdata),
      .halted    (halted)
   );

   // both memories answer in the same cycle
   // fetch outside the loaded program returns a nop
   assign inst_off  = inst_addr - TEXT_W;
   assign inst      = (inst_off < MEM_TOP) ? imem[inst_off[7:0]] : '0;
   assign mem_rdata = (mem_addr < MEM_TOP) ? dmem[mem_addr[7:0]] : '0;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic end_in_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [`WORD_W-1:0] expected,
                             input logic [`WORD_W-1:0] actual);
      if (expected !== actual) begin
         $display("Fail %s expected %h actual %h", name, expected, actual);
         end_in_failure();
      end
   endtask

   // lines are tag, byte address, word; anything after a # is ignored
   task automatic load_stim();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  tag;
      logic [31:0] addr;
      logic [31:0] value;
      logic [31:0] word;
      imem = '{default: '0};
      dmem = '{default: '0};
      prog_words = 0;
      fd = $fopen("core_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open core_stim.txt");
         end_in_failure();
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.getc(0) != 8'h23) begin
            n = $sscanf(line, "%c %h %h", tag, addr, value);
            if (n == 3 && tag == "I") begin
               word = (addr - `TEXT_START) >> 2;
               if (word >= MEM_WORDS) begin
                  $display("program word at %h lies outside instruction memory", addr);
                  end_in_failure();
               end
               imem[word[7:0]] = value;
               prog_words++;
            end else if (n == 3 && tag == "D") begin
               word = addr >> 2;
               if (word >= MEM_WORDS) begin
                  $display("data word at %h lies outside data memory", addr);
                  end_in_failure();
               end
               dmem[word[7:0]] = value;
            end else if (n == 3 && tag == "E") begin
               exp_addr.push_back(addr);
               exp_data.push_back(value);
            end else if (n == 3) begin
               $display("unknown line tag in core_stim.txt");
               end_in_failure();
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic check_reset_outputs(input string phase);
      check_word({phase, " mem_we"}, 32'd0, {31'd0, mem_we});
      check_word({phase, " halted"}, 32'd0, {31'd0, halted});
      check_word({phase, " inst_addr"}, `TEXT_START, {inst_addr, 2'b00});
   endtask

   // called once per cycle at the falling edge
   // every store must be the next one on the list, none after halt
   task automatic watch_stores();
      if (mem_we) begin
         if (halted) begin
            $display("store to %h issued after the core halted", {mem_addr, 2'b00});
            end_in_failure();
         end else if (store_count >= exp_addr.size()) begin
            $display("store to %h goes beyond the expected store list", {mem_addr, 2'b00});
            end_in_failure();
         end else begin
            check_word($sformatf("store %0d address", store_count),
                       exp_addr[store_count], {mem_addr, 2'b00});
            check_word($sformatf("store %0d data", store_count),
                       exp_data[store_count], mem_wdata);
            if (mem_addr < MEM_TOP) begin
               dmem[mem_addr[7:0]] = mem_wdata;
            end
            store_count++;
         end
      end
   endtask

   initial begin
      rst_b       = 1'b0;
      store_count = 0;
      cycles      = 0;
      load_stim();
      cycle_limit = 20 * prog_words + 200;

      // reset held for 16 cycles, outputs quiet throughout
      repeat (16) begin
         @(negedge clk);
         check_reset_outputs("during reset");
      end
      @(posedge clk);
      rst_b <= 1'b1;
      @(negedge clk);
      check_reset_outputs("after reset");

      // run until SYSCALL retires
      while (!halted && cycles < cycle_limit) begin
         @(negedge clk);
         watch_stores();
         cycles++;
      end
      if (!halted) begin
         $display("core did not halt within %0d cycles", cycle_limit);
         end_in_failure();
      end

      // halt is sticky and the data port stays idle
      repeat (HALT_WATCH) begin
         @(negedge clk);
         watch_stores();
         check_word("halted stays high", 32'd1, {31'd0, halted});
      end
      check_word("store count", exp_addr.size(), store_count);

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: core_stim.txt
# columns: tag byte_address word   (I program word, D initial data word,
#          E expected store address and value in program order)
D 00000100 800000f0 # operand a
D 00000104 00000f3c # operand b
I 00400000 8c010100 # lw r1, 0x100(r0)
I 00400004 8c020104 # lw r2, 0x104(r0)
I 00400008 00221820 # add r3, r1, r2 after load-use stall
I 0040000c 00212021 # addu r4, r1, r1
I 00400010 00412822 # sub r5, r2, r1
I 00400014 00223023 # subu r6, r1, r2
I 00400018 00223824 # and r7, r1, r2
I 0040001c 00224025 # or r8, r1, r2
I 00400020 00224826 # xor r9, r1, r2
I 00400024 00225027 # nor r10, r1, r2
I 00400028 0022582a # slt r11, r1, r2
I 0040002c 0022602b # sltu r12, r1, r2
I 00400030 00026900 # sll r13, r2, 4
I 00400034 00017102 # srl r14, r1, 4
I 00400038 00017903 # sra r15, r1, 4
I 0040003c 2030fff0 # addi r16, r1, -16
I 00400040 24517fff # addiu r17, r2, 0x7fff
I 00400044 28528000 # slti r18, r2, -32768
I 00400048 3033fff0 # andi r19, r1, 0xfff0
I 0040004c 34548001 # ori r20, r2, 0x8001
I 00400050 3835ff00 # xori r21, r1, 0xff00
I 00400054 3c161234 # lui r22, 0x1234
I 00400058 ac030200 # sw r3, 0x200(r0)
I 0040005c ac040204 # sw r4, 0x204(r0)
I 00400060 ac050208 # sw r5, 0x208(r0)
I 00400064 ac06020c # sw r6, 0x20c(r0)
I 00400068 ac070210 # sw r7, 0x210(r0)
I 0040006c ac080214 # sw r8, 0x214(r0)
I 00400070 ac090218 # sw r9, 0x218(r0)
I 00400074 ac0a021c # sw r10, 0x21c(r0)
I 00400078 ac0b0220 # sw r11, 0x220(r0)
I 0040007c ac0c0224 # sw r12, 0x224(r0)
I 00400080 ac0d0228 # sw r13, 0x228(r0)
I 00400084 ac0e022c # sw r14, 0x22c(r0)
I 00400088 ac0f0230 # sw r15, 0x230(r0)
I 0040008c ac100234 # sw r16, 0x234(r0)
I 00400090 ac110238 # sw r17, 0x238(r0)
I 00400094 ac12023c # sw r18, 0x23c(r0)
I 00400098 ac130240 # sw r19, 0x240(r0)
I 0040009c ac140244 # sw r20, 0x244(r0)
I 004000a0 ac150248 # sw r21, 0x248(r0)
I 004000a4 ac16024c # sw r22, 0x24c(r0)
I 004000a8 24170005 # addiu r23, r0, 5
I 004000ac 02f7b821 # addu r23, r23, r23 back to back
I 004000b0 0017b840 # sll r23, r23, 1
I 004000b4 ac170250 # sw r23, 0x250(r0) store data forwarded
I 004000b8 8c180200 # lw r24, 0x200(r0)
I 004000bc 0317c821 # addu r25, r24, r23 load-use
I 004000c0 ac190254 # sw r25, 0x254(r0)
I 004000c4 241afffd # addiu r26, r0, -3
I 004000c8 8c1b0104 # lw r27, 0x104(r0)
I 004000cc 001ae023 # subu r28, r0, r26 from two back
I 004000d0 037ce821 # addu r29, r27, r28 load from two back
I 004000d4 ac1d0258 # sw r29, 0x258(r0)
I 004000d8 241e0f3f # addiu r30, r0, 0xf3f
I 004000dc 13be0002 # beq r29, r30, +2 taken
I 004000e0 241a0077 # addiu r26, r0, 0x77 squashed
I 004000e4 ac1e0300 # sw r30, 0x300(r0) squashed
I 004000e8 17be0002 # bne r29, r30, +2 not taken
I 004000ec ac1a025c # sw r26, 0x25c(r0)
I 004000f0 0810003f # j 0x004000fc
I 004000f4 ac1e0304 # sw r30, 0x304(r0) squashed
I 004000f8 241a0055 # addiu r26, r0, 0x55 squashed
I 004000fc ac1a0260 # sw r26, 0x260(r0)
I 00400100 0000000c # syscall
I 00400104 ac1e0308 # sw r30, 0x308(r0) never runs
E 00000200 8000102c
E 00000204 000001e0
E 00000208 80000e4c
E 0000020c 7ffff1b4
E 00000210 00000030
E 00000214 80000ffc
E 00000218 80000fcc
E 0000021c 7ffff003
E 00000220 00000001
E 00000224 00000000
E 00000228 0000f3c0
E 0000022c 0800000f
E 00000230 f800000f
E 00000234 800000e0
E 00000238 00008f3b
E 0000023c 00000000
E 00000240 000000f0
E 00000244 00008f3d
E 00000248 8000fff0
E 0000024c 12340000
E 00000250 00000014
E 00000254 80001040
E 00000258 00000f3f
E 0000025c fffffffd
E 00000260 fffffffd

// File: compile.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
pipe_control.sv
fetch_unit.sv
reg_file.sv
exec_unit.sv
mem_wb_unit.sv
mips_core.sv
tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# build the core testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/10ps -f compile.f --top-module tb_mips_core -o tb_sim &&
./obj_dir/tb_sim || exit 1
